/* project.f */
hdl/delqa_pkg.sv
hdl/delqa_bdl.sv
hdl/delqa_rxbuf.sv
hdl/delqa_lbus_fabric.sv
hdl/delqa_core.sv
tests/tb_clkgen.sv
tests/delqa_chk.sv
tests/tb_delqa.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the delqa testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module tb_delqa -f project.f -o tb_delqa
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/tb_delqa
status=$?
if [ $status -ne 0 ]; then
   echo "simulation failed with status $status"
   exit $status
fi
exit 0

/* tests/tb_delqa.sv */
//******************************
// delqa core testbench
// table of local, dma and ethernet accesses checked
// against a reference model of the bdl and rx buffer
//******************************
`timescale 1ns/1ps

module tb_delqa import delqa_pkg::*;;

   localparam int ACK_TIMEOUT = 4;            // cycles to wait for an ack
   localparam int RST_TIMEOUT = 50;           // cycles to wait for reset release

   typedef enum int {PORT_LB, PORT_DMA, PORT_ETH} port_e;
   typedef enum int {REG_NONE, REG_RXB, REG_BDL} region_e;

   typedef struct {
      string      name;
      port_e      port;
      bit         we;
      logic [15:0] adr;                       // byte address or ethernet word address
      word_t      dat;
      logic [1:0] sel;
      bit         rxm;                        // eth_rxmode_i level for the row
      bit         mapped;
      word_t      exp;                        // expected read word
   } row_t;

   logic              lwb_clkp, wb_rst_i;
   word_t             lwb_adr_i, lwb_dat_i, lwb_dat_o;
   logic [1:0]        lwb_sel_i;
   logic              lwb_we_i, lwb_cyc_i, lwb_stb_i, lwb_ack_o;
   logic [15:1]       dma_lad_i;
   logic              dma_mode_i, dma_we_i;
   word_t             dma_dat_i, dma_dat_o;
   logic              eth_rxmode_i, eth_we_i;
   logic [9:0]        eth_adr_i;
   word_t             eth_dat_i;

   row_t        rows[$];                      // stimulus table
   word_t       bdl_ref [8];                  // model of the descriptor bank
   word_t       rxb_ref [2048];               // model of the rx buffer
   logic [31:0] lcg_state;

   tb_clkgen clk0 (.clk_o(lwb_clkp), .rst_o(wb_rst_i));

   delqa_core dut0 (
      .lwb_clkp (lwb_clkp), .wb_rst_i (wb_rst_i),
      .lwb_adr_i (lwb_adr_i), .lwb_dat_i (lwb_dat_i), .lwb_sel_i (lwb_sel_i),
      .lwb_we_i (lwb_we_i), .lwb_cyc_i (lwb_cyc_i), .lwb_stb_i (lwb_stb_i),
      .lwb_dat_o (lwb_dat_o), .lwb_ack_o (lwb_ack_o),
      .dma_lad_i (dma_lad_i), .dma_mode_i (dma_mode_i), .dma_we_i (dma_we_i),
      .dma_dat_i (dma_dat_i), .dma_dat_o (dma_dat_o),
      .eth_rxmode_i (eth_rxmode_i), .eth_we_i (eth_we_i),
      .eth_adr_i (eth_adr_i), .eth_dat_i (eth_dat_i)
   );

   function automatic word_t next_rand();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state[30:15];                // upper bits spread better
   endfunction

   // byte address map
   function automatic region_e region_of(input logic [15:0] a);
      if (a[15:12] == 4'h1) return REG_RXB;   // 010000-017777
      if (a[15:4] == 12'h280) return REG_BDL; // 024000-024017
      return REG_NONE;
   endfunction

   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("*** FAILED ***");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic check_val(input string name, input word_t exp, input word_t act);
      if (act !== exp) begin
         stop_on_error($sformatf("mismatch %s expected %h actual %h", name, exp, act));
      end
   endtask

   //******************************
   // table build and reference model
   //******************************
   task automatic add_row(input string name, input port_e port, input bit we,
                          input logic [15:0] adr, input word_t dat,
                          input logic [1:0] sel, input bit rxm);
      row_t    r;
      region_e rg;
      rg = region_of(adr);
      r.name = name;
      r.port = port;
      r.we = we;
      r.adr = adr;
      r.dat = dat;
      r.sel = sel;
      r.rxm = rxm;
      r.exp = 16'h0000;                       // unmapped dma reads return zero
      r.mapped = (port == PORT_ETH) || (rg != REG_NONE);
      if (port == PORT_ETH) begin
         rxb_ref[11'(adr[9:0])] = dat;        // lower part of the buffer
      end else if (rg == REG_BDL && we) begin
         if (port == PORT_DMA) begin
            bdl_ref[adr[3:1]] = dat;          // dma writes whole words
         end else begin
            if (sel[0]) bdl_ref[adr[3:1]][7:0] = dat[7:0];
            if (sel[1]) bdl_ref[adr[3:1]][15:8] = dat[15:8];
         end
      end else if (rg == REG_BDL) begin
         r.exp = bdl_ref[adr[3:1]];
      end else if (rg == REG_RXB && we) begin
         if (port == PORT_LB && !rxm) rxb_ref[adr[11:1]] = dat;  // dropped in rx mode
      end else if (rg == REG_RXB) begin
         r.exp = rxb_ref[adr[11:1]];
      end
      rows.push_back(r);
   endtask

   //******************************
   // port drivers entered on a falling edge
   //******************************
   task automatic lb_access(input row_t r);
      bit acked;
      int n;
      acked = 1'b0;
      n = 0;
      lwb_adr_i = r.adr;
      lwb_dat_i = r.dat;
      lwb_sel_i = r.sel;
      lwb_we_i  = r.we;
      lwb_cyc_i = 1'b1;
      lwb_stb_i = 1'b1;
      while (!acked && n < ACK_TIMEOUT) begin
         @(negedge lwb_clkp);
         n++;
         acked = lwb_ack_o;
      end
      if (r.mapped) begin
         if (!acked) stop_on_error({"no ack from a mapped address in ", r.name});
         if (!r.we) check_val(r.name, r.exp, lwb_dat_o);
      end else begin
         check_val({r.name, "_ack"}, 16'h0000, {15'd0, acked});
         check_val(r.name, 16'h0000, lwb_dat_o);   // unmapped reads zero
      end
      lwb_cyc_i = 1'b0;
      lwb_stb_i = 1'b0;
      lwb_we_i  = 1'b0;
      @(negedge lwb_clkp);                    // ack gap
   endtask

   task automatic dma_access(input row_t r);
      dma_lad_i  = r.adr[15:1];
      dma_dat_i  = r.dat;
      dma_we_i   = r.we;
      dma_mode_i = 1'b1;
      @(negedge lwb_clkp);                    // reply is one clock late
      if (!r.we) check_val(r.name, r.exp, dma_dat_o);
      dma_mode_i = 1'b0;
      dma_we_i   = 1'b0;
   endtask

   task automatic eth_write(input row_t r);
      eth_adr_i = r.adr[9:0];
      eth_dat_i = r.dat;
      eth_we_i  = 1'b1;
      @(negedge lwb_clkp);
      eth_we_i  = 1'b0;
   endtask

   //******************************
   // main sequence
   //******************************
   initial begin
      int n;
      lwb_adr_i = '0;
      lwb_dat_i = '0;
      lwb_sel_i = 2'b00;
      lwb_we_i = 1'b0;
      lwb_cyc_i = 1'b0;
      lwb_stb_i = 1'b0;
      dma_lad_i = '0;
      dma_mode_i = 1'b0;
      dma_we_i = 1'b0;
      dma_dat_i = '0;
      eth_rxmode_i = 1'b0;
      eth_we_i = 1'b0;
      eth_adr_i = '0;
      eth_dat_i = '0;
      lcg_state = 32'd62;
      foreach (bdl_ref[i]) bdl_ref[i] = 16'h0000;  // bank clears on reset

      add_row("bdl_wr_word", PORT_LB, 1, 16'h2804, next_rand(), 2'b11, 0);
      add_row("bdl_wr_hi", PORT_LB, 1, 16'h2804, next_rand(), 2'b10, 0);
      add_row("bdl_rd_hi", PORT_LB, 0, 16'h2804, 16'h0, 2'b11, 0);
      add_row("bdl_wr_lo", PORT_LB, 1, 16'h280a, next_rand(), 2'b01, 0);
      add_row("bdl_rd_lo", PORT_LB, 0, 16'h280a, 16'h0, 2'b11, 0);
      add_row("eth_wr", PORT_ETH, 1, 16'h0015, next_rand(), 2'b11, 1);
      add_row("eth_lb_rd", PORT_LB, 0, 16'h102a, 16'h0, 2'b11, 1);
      add_row("rx_lb_wr_drop", PORT_LB, 1, 16'h102a, next_rand(), 2'b11, 1);
      add_row("eth_lb_rd_kept", PORT_LB, 0, 16'h102a, 16'h0, 2'b11, 0);
      for (int i = 0; i < 4; i++) begin
         add_row($sformatf("rxb_fill_%0d", i), PORT_LB, 1, 16'h1100 + 16'(i * 34),
                 next_rand(), 2'b11, 0);
      end
      for (int i = 0; i < 4; i++) begin
         add_row($sformatf("rxb_dma_rd_%0d", i), PORT_DMA, 0, 16'h1100 + 16'(i * 34),
                 16'h0, 2'b11, 0);
      end
      add_row("eth_dma_rd", PORT_DMA, 0, 16'h102a, 16'h0, 2'b11, 0);
      add_row("bdl_dma_rd", PORT_DMA, 0, 16'h2804, 16'h0, 2'b11, 0);
      add_row("none_dma_rd", PORT_DMA, 0, 16'h3000, 16'h0, 2'b11, 0);
      add_row("bdl_dma_wr", PORT_DMA, 1, 16'h280e, next_rand(), 2'b11, 0);
      add_row("bdl_rd_dma_wr", PORT_LB, 0, 16'h280e, 16'h0, 2'b11, 0);
      add_row("none_lb_rd", PORT_LB, 0, 16'h4000, 16'h0, 2'b11, 0);
      add_row("none_lb_rd_bdl_end", PORT_LB, 0, 16'h2810, 16'h0, 2'b11, 0);
      add_row("bdl_rd_after_none", PORT_LB, 0, 16'h2804, 16'h0, 2'b11, 0);

      n = 0;
      @(negedge lwb_clkp);
      while (wb_rst_i && n < RST_TIMEOUT) begin
         @(negedge lwb_clkp);
         n++;
      end
      if (wb_rst_i) stop_on_error("reset was never released");
      check_val("rst_ack", 16'h0000, {15'd0, lwb_ack_o});
      check_val("rst_dma", 16'h0000, dma_dat_o);

      foreach (rows[i]) begin
         eth_rxmode_i = rows[i].rxm;
         case (rows[i].port)
            PORT_LB:  lb_access(rows[i]);
            PORT_DMA: dma_access(rows[i]);
            default:  eth_write(rows[i]);
         endcase
      end
      $display("*** PASSED ***");
      $finish;
   end

endmodule

/* tests/delqa_chk.sv */
//******************************
// bus fabric protocol checks
// ack pulse shape, ack source, dma reply after reset
//******************************
`timescale 1ns/1ps

module delqa_chk import delqa_pkg::*; (
   input logic  lwb_clkp,                     // bus clock
   input logic  wb_rst_i,                     // async reset
   input logic  bdl_stb_i,                    // strobe into bdl
   input logic  rxb_stb_i,                    // strobe into rx buffer
   input logic  lwb_ack_i,                    // merged ack
   input word_t dma_dat_i                     // merged dma reply
);

   // one pulse, then at least one low cycle
   ack_gap: assert property (@(posedge lwb_clkp) disable iff (wb_rst_i)
      lwb_ack_i |=> !lwb_ack_i)
      else $error("local ack high on two cycles in a row");

   // an ack needs a mapped strobe one clock before
   ack_src: assert property (@(posedge lwb_clkp) disable iff (wb_rst_i)
      lwb_ack_i |-> $past(bdl_stb_i || rxb_stb_i))
      else $error("local ack without a strobed mapped cycle");

   dma_rst: assert property (@(posedge lwb_clkp) $fell(wb_rst_i) |-> (dma_dat_i == '0))
      else $error("dma reply not zero after reset");

endmodule

bind delqa_lbus_fabric delqa_chk chk0 (
   .lwb_clkp  (lwb_clkp),
   .wb_rst_i  (wb_rst_i),
   .bdl_stb_i (bdl_stb_o),
   .rxb_stb_i (rxb_stb_o),
   .lwb_ack_i (lwb_ack_o),
   .dma_dat_i (dma_dat_o)
);

/* tests/tb_clkgen.sv */
//******************************
// testbench clock and reset
// 8 ns clock, reset held for a set number of cycles
//******************************
`timescale 1ns/1ps

module tb_clkgen #(
   parameter int RST_CYCLES = 10              // reset length in clocks
) (
   output logic clk_o,                        // bus clock
   output logic rst_o                         // async reset, active high
);

   initial begin
      clk_o = 1'b0;
      forever #4 clk_o = ~clk_o;              // 8 ns period
   end

   initial begin
      rst_o = 1'b1;
      repeat (RST_CYCLES) @(posedge clk_o);
      @(negedge clk_o);
      rst_o = 1'b0;                           // released away from the rising edge
   end

endmodule

/* hdl/delqa_core.sv */
//******************************
// delqa local bus core
// bdl bank and receive buffer joined by the bus fabric
//******************************
`timescale 1ns/1ps

module delqa_core import delqa_pkg::*; #(
   parameter int RXB_AW = RXB_AW_DEF,         // rx buffer word address width
   parameter int BDL_AW = BDL_AW_DEF,         // bdl word address width
   parameter int ETH_AW = ETH_AW_DEF          // ethernet write address width
) (
   input  logic              lwb_clkp,        // bus clock
   input  logic              wb_rst_i,        // async reset
   // local bus
   input  word_t             lwb_adr_i,       // byte address
   input  word_t             lwb_dat_i,       // write data
   input  logic [1:0]        lwb_sel_i,       // byte selects
   input  logic              lwb_we_i,        // write enable
   input  logic              lwb_cyc_i,       // bus cycle
   input  logic              lwb_stb_i,       // transfer strobe
   output word_t             lwb_dat_o,       // read data
   output logic              lwb_ack_o,       // ack
   // dma port
   input  logic [15:1]       dma_lad_i,       // dma word address
   input  logic              dma_mode_i,      // dma access active
   input  logic              dma_we_i,        // dma write
   input  word_t             dma_dat_i,       // dma write data
   output word_t             dma_dat_o,       // dma read data
   // ethernet receive port
   input  logic              eth_rxmode_i,    // ethernet owns rx buffer writes
   input  logic              eth_we_i,        // ethernet word write
   input  logic [ETH_AW-1:0] eth_adr_i,       // ethernet word address
   input  word_t             eth_dat_i        // received word
);

   //******************************
   // fabric to slave nets
   //******************************
   logic  bdl_stb, bdl_dma_we, bdl_ack;       // bdl control
   word_t bdl_dat, bdl_dma_dat;               // bdl read words
   logic  rxb_stb, rxb_ack;                   // rx buffer control
   word_t rxb_dat, rxb_dma_dat;               // rx buffer read words

   delqa_lbus_fabric fab0 (
      .lwb_clkp      (lwb_clkp),
      .wb_rst_i      (wb_rst_i),
      .lwb_adr_i     (lwb_adr_i),
      .lwb_cyc_i     (lwb_cyc_i),
      .lwb_stb_i     (lwb_stb_i),
      .lwb_we_i      (lwb_we_i),
      .dma_lad_i     (dma_lad_i),
      .dma_mode_i    (dma_mode_i),
      .dma_we_i      (dma_we_i),
      .bdl_stb_o     (bdl_stb),
      .bdl_dma_we_o  (bdl_dma_we),
      .rxb_stb_o     (rxb_stb),
      .bdl_dat_i     (bdl_dat),
      .bdl_ack_i     (bdl_ack),
      .bdl_dma_dat_i (bdl_dma_dat),
      .rxb_dat_i     (rxb_dat),
      .rxb_ack_i     (rxb_ack),
      .rxb_dma_dat_i (rxb_dma_dat),
      .lwb_dat_o     (lwb_dat_o),
      .lwb_ack_o     (lwb_ack_o),
      .dma_dat_o     (dma_dat_o)
   );

   delqa_bdl #(.BDL_AW(BDL_AW)) bdl0 (
      .lwb_clkp  (lwb_clkp),
      .wb_rst_i  (wb_rst_i),
      .stb_i     (bdl_stb),
      .we_i      (lwb_we_i),
      .sel_i     (lwb_sel_i),
      .adr_i     (lwb_adr_i[BDL_AW:1]),       // word within the bdl page
      .dat_i     (lwb_dat_i),
      .dat_o     (bdl_dat),
      .ack_o     (bdl_ack),
      .dma_adr_i (dma_lad_i[BDL_AW:1]),
      .dma_we_i  (bdl_dma_we),
      .dma_dat_i (dma_dat_i),
      .dma_dat_o (bdl_dma_dat)
   );

   delqa_rxbuf #(.RXB_AW(RXB_AW), .ETH_AW(ETH_AW)) rxb0 (
      .lwb_clkp     (lwb_clkp),
      .wb_rst_i     (wb_rst_i),
      .stb_i        (rxb_stb),
      .we_i         (lwb_we_i),
      .adr_i        (lwb_adr_i[RXB_AW:1]),    // word within the rx page
      .dat_i        (lwb_dat_i),
      .dat_o        (rxb_dat),
      .ack_o        (rxb_ack),
      .dma_adr_i    (dma_lad_i[RXB_AW:1]),
      .dma_dat_o    (rxb_dma_dat),
      .eth_rxmode_i (eth_rxmode_i),
      .eth_we_i     (eth_we_i),
      .eth_adr_i    (eth_adr_i),
      .eth_dat_i    (eth_dat_i)
   );

endmodule

/* hdl/delqa_lbus_fabric.sv */
//******************************
// local bus fabric
// address decode for local bus and dma, ack merge,
// read data multiplexing for both replies
//******************************
`timescale 1ns/1ps

module delqa_lbus_fabric import delqa_pkg::*; (
   input  logic        lwb_clkp,              // bus clock
   input  logic        wb_rst_i,              // async reset
   // local bus master
   input  word_t       lwb_adr_i,             // byte address
   input  logic        lwb_cyc_i,             // bus cycle
   input  logic        lwb_stb_i,             // transfer strobe
   input  logic        lwb_we_i,              // write enable
   // dma port
   input  logic [15:1] dma_lad_i,             // dma word address
   input  logic        dma_mode_i,            // dma access active
   input  logic        dma_we_i,              // dma write request
   // slave strobes
   output logic        bdl_stb_o,             // bdl local strobe
   output logic        bdl_dma_we_o,          // bdl dma write
   output logic        rxb_stb_o,             // rx buffer local strobe
   // slave returns
   input  word_t       bdl_dat_i,             // bdl local read word
   input  logic        bdl_ack_i,             // bdl ack
   input  word_t       bdl_dma_dat_i,         // bdl dma read word
   input  word_t       rxb_dat_i,             // rx buffer local read word
   input  logic        rxb_ack_i,             // rx buffer ack
   input  word_t       rxb_dma_dat_i,         // rx buffer dma read word
   // merged replies
   output word_t       lwb_dat_o,             // local read data
   output logic        lwb_ack_o,             // local ack
   output word_t       dma_dat_o              // dma read data
);

   lb_target_e lb_tgt;                        // local bus target
   lb_target_e dma_tgt;                       // dma target this cycle
   lb_target_e dma_tgt_q;                     // dma target of last cycle
   logic       lb_go;                         // strobed local cycle

   // page compare shared by both address paths
   function automatic lb_target_e decode_tgt(input logic [15:4] pg);
      if (pg[15:12] == RXB_PAGE) begin
         return TGT_RXB;
      end else if (pg == BDL_PAGE) begin
         return TGT_BDL;
      end
      return TGT_NONE;
   endfunction

   //******************************
   // local bus decode
   //******************************
   assign lb_tgt    = decode_tgt(lwb_adr_i[15:4]);
   assign lb_go     = lwb_cyc_i & lwb_stb_i;
   assign bdl_stb_o = lb_go & (lb_tgt == TGT_BDL);
   assign rxb_stb_o = lb_go & (lb_tgt == TGT_RXB);
   assign lwb_ack_o = bdl_ack_i | rxb_ack_i;  // unmapped never acks

   always_comb begin
      lwb_dat_o = '0;                         // zero for writes and unmapped
      if (!lwb_we_i) begin
         case (lb_tgt)
            TGT_RXB: lwb_dat_o = rxb_dat_i;
            TGT_BDL: lwb_dat_o = bdl_dat_i;
            default: lwb_dat_o = '0;
         endcase
      end
   end

   //******************************
   // dma decode and return path
   //******************************
   assign dma_tgt      = dma_mode_i ? decode_tgt(dma_lad_i[15:4]) : TGT_NONE;
   assign bdl_dma_we_o = dma_we_i & (dma_tgt == TGT_BDL);  // only bdl is writable

   always_ff @(posedge lwb_clkp or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         dma_tgt_q <= TGT_NONE;               // zero reply after reset
      end else begin
         dma_tgt_q <= dma_tgt;                // matches slave read register
      end
   end

   always_comb begin
      case (dma_tgt_q)
         TGT_RXB: dma_dat_o = rxb_dma_dat_i;
         TGT_BDL: dma_dat_o = bdl_dma_dat_i;
         default: dma_dat_o = '0;             // no block selected
      endcase
   end

endmodule

/* hdl/delqa_rxbuf.sv */
//******************************
// receive buffer memory
// one write port shared by ethernet and local bus,
// separate registered reads for local bus and dma
//******************************
`timescale 1ns/1ps

module delqa_rxbuf import delqa_pkg::*; #(
   parameter int RXB_AW = RXB_AW_DEF,         // buffer word address width
   parameter int ETH_AW = ETH_AW_DEF          // ethernet write address width
) (
   input  logic              lwb_clkp,        // bus clock
   input  logic              wb_rst_i,        // async reset
   // local bus side
   input  logic              stb_i,           // decoded strobe
   input  logic              we_i,            // write enable
   input  logic [RXB_AW-1:0] adr_i,           // word address
   input  word_t             dat_i,           // write data
   output word_t             dat_o,           // read data, valid with ack
   output logic              ack_o,           // one cycle ack
   // dma side
   input  logic [RXB_AW-1:0] dma_adr_i,       // dma word address
   output word_t             dma_dat_o,       // dma read data, one clock late
   // ethernet receive side
   input  logic              eth_rxmode_i,    // ethernet owns the write port
   input  logic              eth_we_i,        // ethernet word write
   input  logic [ETH_AW-1:0] eth_adr_i,       // ethernet word address
   input  word_t             eth_dat_i        // received word
);

   localparam int RXB_N = 2**RXB_AW;          // buffer depth in words

   word_t              mem [RXB_N];           // buffer storage
   logic               wr_en;                 // shared write strobe
   logic [RXB_AW-1:0]  wr_adr;                // shared write address
   word_t              wr_dat;                // shared write data

   //******************************
   // write port arbitration
   //******************************
   always_comb begin
      if (eth_rxmode_i) begin
         wr_en  = eth_we_i;                   // local writes dropped here
         wr_adr = RXB_AW'(eth_adr_i);         // lower part of the buffer
         wr_dat = eth_dat_i;
      end else begin
         wr_en  = stb_i & we_i & ~ack_o;      // store on the acked edge
         wr_adr = adr_i;
         wr_dat = dat_i;
      end
   end

   // local ack still given in rx mode
   always_ff @(posedge lwb_clkp or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         ack_o <= 1'b0;
      end else begin
         ack_o <= stb_i & ~ack_o;             // pulse, then gap
      end
   end

   //******************************
   // memory array and reads
   //******************************
   always_ff @(posedge lwb_clkp) begin
      if (wr_en) begin
         mem[wr_adr] <= wr_dat;
      end
      if (stb_i) begin
         dat_o <= mem[adr_i];                 // old word on write cycle
      end
      dma_dat_o <= mem[dma_adr_i];            // free running dma read
   end

endmodule

/* hdl/delqa_bdl.sv */
//******************************
// bdl register bank
// eight descriptor words, byte writes from the local bus,
// word writes and reads from the dma side
//******************************
`timescale 1ns/1ps

module delqa_bdl import delqa_pkg::*; #(
   parameter int BDL_AW = BDL_AW_DEF          // word address width
) (
   input  logic              lwb_clkp,        // bus clock
   input  logic              wb_rst_i,        // async reset
   // local bus side
   input  logic              stb_i,           // decoded strobe
   input  logic              we_i,            // write enable
   input  logic [1:0]        sel_i,           // byte selects
   input  logic [BDL_AW-1:0] adr_i,           // word address
   input  word_t             dat_i,           // write data
   output word_t             dat_o,           // read data, valid with ack
   output logic              ack_o,           // one cycle ack
   // dma side
   input  logic [BDL_AW-1:0] dma_adr_i,       // dma word address
   input  logic              dma_we_i,        // dma word write
   input  word_t             dma_dat_i,       // dma write data
   output word_t             dma_dat_o        // dma read data, one clock late
);

   localparam int BDL_N = 2**BDL_AW;          // number of descriptor words

   word_t bdl_q [BDL_N];                      // descriptor registers
   logic  lb_wr;                              // local write on the acked edge

   assign lb_wr = stb_i & we_i & ~ack_o;      // one store per ack

   //******************************
   // ack, one pulse then one gap
   //******************************
   always_ff @(posedge lwb_clkp or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         ack_o <= 1'b0;
      end else begin
         ack_o <= stb_i & ~ack_o;             // withheld after a pulse
      end
   end

   //******************************
   // register writes
   //******************************
   always_ff @(posedge lwb_clkp or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         for (int i = 0; i < BDL_N; i++) begin
            bdl_q[i] <= '0;                   // descriptors cleared
         end
      end else begin
         for (int i = 0; i < BDL_N; i++) begin
            if (dma_we_i && (dma_adr_i == BDL_AW'(i))) begin
               bdl_q[i] <= dma_dat_i;         // dma has priority
            end else if (lb_wr && (adr_i == BDL_AW'(i))) begin
               if (sel_i[0]) bdl_q[i][7:0]  <= dat_i[7:0];   // low byte
               if (sel_i[1]) bdl_q[i][15:8] <= dat_i[15:8];  // high byte
            end
         end
      end
   end

   //******************************
   // registered reads
   //******************************
   always_ff @(posedge lwb_clkp) begin
      if (stb_i) begin
         dat_o <= bdl_q[adr_i];               // aligned with ack
      end
      dma_dat_o <= bdl_q[dma_adr_i];          // every cycle, fabric selects
   end

endmodule

/* hdl/delqa_pkg.sv */
//******************************
// delqa shared definitions
// bus word type, decoded target enum and the local-bus address map
//******************************
package delqa_pkg;

   //******************************
   // bus word
   //******************************
   typedef logic [15:0] word_t;               // local bus and dma data word

   //******************************
   // decoded bus target
   //******************************
   typedef enum logic [1:0] {
      TGT_NONE = 2'b00,                       // unmapped, no ack
      TGT_RXB  = 2'b01,                       // receive buffer
      TGT_BDL  = 2'b10                        // bdl register bank
   } lb_target_e;

   //******************************
   // address map, byte addresses
   //******************************
   // receive buffer 010000-017777, matched on bits 15..12
   localparam logic [3:0]  RXB_PAGE = 4'b0001;

   // bdl registers 024000-024017, matched on bits 15..4
   localparam logic [11:0] BDL_PAGE = 12'b0010_1000_0000;

   //******************************
   // default sizes
   //******************************
   localparam int RXB_AW_DEF = 11;            // 2048 words, 4 kbyte page
   localparam int BDL_AW_DEF = 3;             // eight descriptor words
   localparam int ETH_AW_DEF = 10;            // ethernet fills lower half

endpackage
